// File: Makefile
# Verilator build and run of the cache testbench

SRCS = cache_pkg.sv tag_lookup.sv cache_controller.sv data_store.sv mem_port.sv \
       cache_top.sv main_memory_model.sv tb_cache.sv

.PHONY: run clean

run: obj_dir/Vtb_cache
	./obj_dir/Vtb_cache | tee sim.log
	grep -q "^TEST PASS$$" sim.log

obj_dir/Vtb_cache: $(SRCS) tb.f
	verilator --binary --timing --assert --top-module tb_cache -f tb.f -o Vtb_cache

clean:
	rm -rf obj_dir sim.log

// File: cache_controller.sv
////////////////////////////////////////////////////////////////////////////
// request FSM of the cache: IDLE, LOOKUP, then either back to IDLE on a
// hit or through FILL on a miss; a filled request is replayed from IDLE
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cache_controller
    import cache_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         enable,
    input  logic         wr,
    input  logic         hit,
    input  logic         hit_way,
    input  logic         victim_way,
    input  logic         fill_done,      // last fill word has been written
    output cache_state_t state,
    output logic         lru_touch,
    output logic         tag_write,
    output logic         write_way,
    output logic         hit_write,
    output logic         read_hit,
    output logic         data_valid,
    output logic         fill_start,
    output logic         fill_way,
    output logic         write_through
);

    logic replay;                        // filled request waits in IDLE for its second lookup

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            replay     <= 1'b0;
            data_valid <= 1'b0;
            fill_way   <= 1'b0;
        end else begin
            data_valid <= (state == LOOKUP) && hit;  // lands together with data_out
            if (fill_start) begin
                fill_way <= victim_way;  // held for the whole fill and the tag write
            end
            case (state)
                IDLE: begin
                    if (enable || replay) begin
                        state  <= LOOKUP;
                        replay <= 1'b0;
                    end
                end
                LOOKUP: begin
                    state <= hit ? IDLE : FILL;
                end
                FILL: begin
                    if (fill_done) begin
                        state  <= IDLE;
                        replay <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // hit service strobes, all live in the single LOOKUP cycle
    assign lru_touch     = (state == LOOKUP) && hit;
    assign read_hit      = (state == LOOKUP) && hit && !wr;
    assign hit_write     = (state == LOOKUP) && hit && wr;
    assign write_through = hit_write;    // the word goes to memory as the way is updated

    // miss handling
    assign fill_start = (state == LOOKUP) && !hit;
    assign tag_write  = (state == FILL) && fill_done;
    assign write_way  = fill_way;

    // data_valid closes one single LOOKUP cycle that IDLE opened and IDLE follows
    assert property (@(posedge clk) disable iff (reset)
        data_valid |-> (state == IDLE) && ($past(state) == LOOKUP)
                       && ($past(state, 2) == IDLE))
        else $error("cache_controller: data_valid outside LOOKUP");

    // the memory port only finishes a fill that this FSM is waiting for
    assert property (@(posedge clk) disable iff (reset) fill_done |-> state == FILL)
        else $error("cache_controller: fill_done outside FILL");

    // the replayed lookup must find the block in the way that was just filled
    assert property (@(posedge clk) disable iff (reset)
        (state == LOOKUP) && ($past(state, 2) == FILL) |-> hit && (hit_way == fill_way))
        else $error("cache_controller: replay after fill did not hit the filled way");

endmodule

// File: cache_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared geometry, address field widths and controller states of the
// two-way L1 data cache; every cache module pulls these in through a
// wildcard import in its header
////////////////////////////////////////////////////////////////////////////
package cache_pkg;

    // word and address widths of the 16-bit byte-addressed memory system
    localparam int ADDR_W = 16;    // byte address width
    localparam int DATA_W = 16;    // one word per access

    // cache geometry
    localparam int SET_BITS  = 6;  // 64 sets unless the top level overrides it
    localparam int WORD_BITS = 3;  // eight words in a block
    localparam int WAYS      = 2;  // two-way set associative

    // what is left of the address once set, word and byte select are taken
    localparam int TAG_BITS = ADDR_W - SET_BITS - WORD_BITS - 1;

    // controller states, in the order a request walks through them
    typedef enum logic [1:0] {
        IDLE   = 2'd0,             // no request open, or waiting to replay a filled one
        LOOKUP = 2'd1,             // registered tags are compared in this cycle
        FILL   = 2'd2              // block is streaming in from main memory
    } cache_state_t;

endpackage

// File: cache_top.sv
////////////////////////////////////////////////////////////////////////////
// top level of the two-way, write-through, write-allocate L1 data cache
// splits the request address and wires tag lookup, controller, data store
// and the main-memory port together
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
#(
    parameter int SET_BITS = cache_pkg::SET_BITS   // set index width for both arrays
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable,              // one-cycle request strobe
    input  logic              wr,                  // high for a write request
    input  logic [ADDR_W-1:0] addr,                // held until data_valid
    input  logic [DATA_W-1:0] data_in,             // write data, held like addr
    input  logic [DATA_W-1:0] mem_out,             // word returned by main memory
    input  logic              mem_valid,           // one pulse per returned word
    output logic [DATA_W-1:0] data_out,
    output logic              data_valid,          // read data ready or write done
    output logic              mem_enable,
    output logic              mem_wr,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_in
);

    logic [TAG_BITS-1:0]  addr_tag;    // upper address bits
    logic [SET_BITS-1:0]  addr_set;    // selects the set in both ways
    logic [WORD_BITS-1:0] addr_word;   // word inside the block, byte bit dropped

    logic                 hit;         // lookup result, valid in LOOKUP
    logic                 hit_way;
    logic                 victim_way;  // LRU way of the looked-up set
    logic                 lru_touch;
    logic                 tag_write;
    logic                 write_way;
    logic                 hit_write;
    logic                 read_hit;
    logic                 fill_start;
    logic                 fill_way;    // latched victim for the running fill
    logic                 write_through;
    logic                 fill_done;
    logic                 fill_write;
    logic [WORD_BITS-1:0] fill_word;
    logic [DATA_W-1:0]    fill_data;

    assign addr_tag  = addr[ADDR_W-1 -: TAG_BITS];
    assign addr_set  = addr[WORD_BITS+1 +: SET_BITS];
    assign addr_word = addr[1 +: WORD_BITS];

    tag_lookup #(.SET_BITS(SET_BITS)) u_lookup (
        .clk        (clk),
        .reset      (reset),
        .lookup_set (addr_set),
        .lookup_tag (addr_tag),
        .lru_touch  (lru_touch),
        .touch_way  (hit_way),         // a hit makes its own way most recent
        .tag_write  (tag_write),
        .write_way  (write_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    cache_controller u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .wr            (wr),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .fill_done     (fill_done),
        .state         (),             // only looked at inside the controller
        .lru_touch     (lru_touch),
        .tag_write     (tag_write),
        .write_way     (write_way),
        .hit_write     (hit_write),
        .read_hit      (read_hit),
        .data_valid    (data_valid),
        .fill_start    (fill_start),
        .fill_way      (fill_way),
        .write_through (write_through)
    );

    data_store #(.SET_BITS(SET_BITS)) u_store (
        .clk        (clk),
        .set        (addr_set),
        .word       (addr_word),
        .hit_write  (hit_write),
        .read_hit   (read_hit),
        .hit_way    (hit_way),
        .write_data (data_in),
        .fill_write (fill_write),
        .fill_way   (fill_way),
        .fill_word  (fill_word),
        .fill_data  (fill_data),
        .data_out   (data_out)
    );

    mem_port u_mem_port (
        .clk           (clk),
        .reset         (reset),
        .req_addr      (addr),
        .write_data    (data_in),
        .fill_start    (fill_start),
        .fill_way      (fill_way),
        .write_through (write_through),
        .mem_out       (mem_out),
        .mem_valid     (mem_valid),
        .mem_enable    (mem_enable),
        .mem_wr        (mem_wr),
        .mem_addr      (mem_addr),
        .mem_in        (mem_in),
        .fill_write    (fill_write),
        .fill_word     (fill_word),
        .fill_data     (fill_data),
        .fill_done     (fill_done)
    );

endmodule

// File: data_store.sv
////////////////////////////////////////////////////////////////////////////
// word arrays of both ways with a registered read of the addressed word
// and the output data register loaded from the hit way on a read hit
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module data_store
    import cache_pkg::*;
#(
    parameter int SET_BITS = cache_pkg::SET_BITS   // number of set index bits
) (
    input  logic                 clk,
    input  logic [SET_BITS-1:0]  set,
    input  logic [WORD_BITS-1:0] word,
    input  logic                 hit_write,        // write hit stores write_data
    input  logic                 read_hit,         // load data_out from the hit way
    input  logic                 hit_way,
    input  logic [DATA_W-1:0]    write_data,
    input  logic                 fill_write,       // one returned fill word
    input  logic                 fill_way,
    input  logic [WORD_BITS-1:0] fill_word,
    input  logic [DATA_W-1:0]    fill_data,
    output logic [DATA_W-1:0]    data_out
);

    localparam int SETS  = 1 << SET_BITS;
    localparam int WORDS = 1 << WORD_BITS;

    logic [DATA_W-1:0] blocks [WAYS][SETS][WORDS];  // every way holds SETS blocks
    logic [DATA_W-1:0] rd_q [WAYS];                 // addressed word of each way

    always_ff @(posedge clk) begin
        if (fill_write) begin
            blocks[fill_way][set][fill_word] <= fill_data;  // fill wins over a hit write
        end else if (hit_write) begin
            blocks[hit_way][set][word] <= write_data;
        end
        for (int w = 0; w < WAYS; w++) begin
            rd_q[w] <= blocks[w][set][word];       // ready for the LOOKUP cycle
        end
        if (read_hit) begin
            data_out <= rd_q[hit_way];
        end
    end

endmodule

// File: main_memory_model.sv
////////////////////////////////////////////////////////////////////////////
// main memory for the cache testbench: each word starts as its word
// address XOR a5a5, reads answer in order LATENCY cycles later with one
// mem_valid pulse, write-through writes update the array at once
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module main_memory_model
    import cache_pkg::*;
#(
    parameter int LATENCY = 4                      // at least one cycle
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_enable,
    input  logic              mem_wr,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic [DATA_W-1:0] mem_in,
    output logic [DATA_W-1:0] mem_out,
    output logic              mem_valid
);

    localparam int WORDS = 1 << (ADDR_W - 1);      // whole byte address space as words

    logic [DATA_W-1:0] words [WORDS];
    logic [DATA_W-1:0] pipe_data [LATENCY];        // read data on its way back
    logic              pipe_valid [LATENCY];

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            words[i] = i[DATA_W-1:0] ^ 16'hA5A5;   // pattern covers every address bit
        end
    end

    always @(posedge clk) begin
        if (mem_enable && mem_wr) begin
            words[mem_addr[ADDR_W-1:1]] <= mem_in;  // byte bit is ignored
        end
        pipe_data[0] <= words[mem_addr[ADDR_W-1:1]];
        for (int s = 1; s < LATENCY; s++) begin
            pipe_data[s] <= pipe_data[s-1];
        end
        if (reset) begin
            for (int s = 0; s < LATENCY; s++) begin
                pipe_valid[s] <= 1'b0;
            end
        end else begin
            pipe_valid[0] <= mem_enable && !mem_wr;  // only reads get an answer
            for (int s = 1; s < LATENCY; s++) begin
                pipe_valid[s] <= pipe_valid[s-1];
            end
        end
    end

    assign mem_out   = pipe_data[LATENCY-1];
    assign mem_valid = pipe_valid[LATENCY-1];

endmodule

// File: mem_port.sv
////////////////////////////////////////////////////////////////////////////
// main-memory side of the cache: issues the eight word reads of a block
// fill, steers returned words into the victim way and registers the
// write-through of a write hit; idle outputs are driven low
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_port
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [ADDR_W-1:0]    req_addr,       // held request address
    input  logic [DATA_W-1:0]    write_data,
    input  logic                 fill_start,     // miss seen in LOOKUP
    input  logic                 fill_way,
    input  logic                 write_through,  // write hit in LOOKUP
    input  logic [DATA_W-1:0]    mem_out,
    input  logic                 mem_valid,
    output logic                 mem_enable,
    output logic                 mem_wr,
    output logic [ADDR_W-1:0]    mem_addr,
    output logic [DATA_W-1:0]    mem_in,
    output logic                 fill_write,
    output logic [WORD_BITS-1:0] fill_word,
    output logic [DATA_W-1:0]    fill_data,
    output logic                 fill_done
);

    logic                 issuing;       // block reads still to go out after this one
    logic [WORD_BITS-1:0] issue_cnt;     // next word to request, wraps to 0 after a fill
    logic                 fill_pending;  // some fill words not yet returned
    logic [WORD_BITS-1:0] ret_cnt;       // slot of the next returned word
    logic [ADDR_W-1:0]    fill_addr;

    // block base of the request with the word offset of the next read
    assign fill_addr = {req_addr[ADDR_W-1:WORD_BITS+1], issue_cnt, 1'b0};

    always_ff @(posedge clk) begin
        if (reset) begin
            issuing      <= 1'b0;
            issue_cnt    <= '0;
            fill_pending <= 1'b0;
            ret_cnt      <= '0;
            fill_done    <= 1'b0;
            mem_enable   <= 1'b0;
            mem_wr       <= 1'b0;
        end else begin
            mem_enable <= write_through || fill_start || issuing;
            mem_wr     <= write_through;
            if (fill_start || issuing) begin
                issue_cnt <= issue_cnt + 1'b1;
                issuing   <= ~&issue_cnt;          // stop once word 7 has gone out
            end
            if (fill_start) begin
                fill_pending <= 1'b1;
            end
            if (mem_valid) begin
                ret_cnt <= ret_cnt + 1'b1;
                if (&ret_cnt) begin
                    fill_pending <= 1'b0;          // eighth word is being written now
                end
            end
            fill_done <= mem_valid && (&ret_cnt);  // one cycle after the last write
        end
    end

    always_ff @(posedge clk) begin
        if (write_through) begin
            mem_addr <= req_addr;
            mem_in   <= write_data;
        end else if (fill_start || issuing) begin
            mem_addr <= fill_addr;
            mem_in   <= '0;
        end else begin
            mem_addr <= '0;
            mem_in   <= '0;
        end
    end

    // words come back in request order, so the return count is the word slot
    assign fill_write = mem_valid;
    assign fill_word  = ret_cnt;
    assign fill_data  = mem_out;

    // memory answers only reads that a running fill has issued
    assert property (@(posedge clk) disable iff (reset) mem_valid |-> fill_pending)
        else $error("mem_port: mem_valid with no fill outstanding");

    // the controller must hold the victim way while its words land
    assert property (@(posedge clk) disable iff (reset) mem_valid |-> $stable(fill_way))
        else $error("mem_port: fill way changed during a fill");

endmodule

// File: tag_lookup.sv
////////////////////////////////////////////////////////////////////////////
// tag, valid and LRU storage for both ways; the set is read into registers
// one cycle after it is presented, so hit and victim are valid in LOOKUP
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tag_lookup
    import cache_pkg::*;
#(
    parameter int SET_BITS = cache_pkg::SET_BITS   // number of set index bits
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [SET_BITS-1:0] lookup_set,
    input  logic [TAG_BITS-1:0] lookup_tag,
    input  logic                lru_touch,         // hit in LOOKUP updates recency
    input  logic                touch_way,
    input  logic                tag_write,         // end of a fill installs the tag
    input  logic                write_way,
    output logic                hit,
    output logic                hit_way,
    output logic                victim_way
);

    localparam int SETS = 1 << SET_BITS;

    logic [TAG_BITS-1:0] tags [WAYS][SETS];  // one tag per block
    logic [SETS-1:0]     valid [WAYS];       // one valid bit per block
    logic [SETS-1:0]     lru;                // bit per set names the least recent way

    logic [TAG_BITS-1:0] tag_q [WAYS];       // registered read of the set
    logic [WAYS-1:0]     valid_q;
    logic                lru_q;
    logic [TAG_BITS-1:0] req_tag_q;          // request tag lined up with tag_q
    logic [WAYS-1:0]     way_hit;

    always_ff @(posedge clk) begin
        if (tag_write) begin
            tags[write_way][lookup_set] <= lookup_tag;  // request is still held at fill end
        end
        for (int w = 0; w < WAYS; w++) begin
            tag_q[w] <= tags[w][lookup_set];
        end
        req_tag_q <= lookup_tag;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WAYS; w++) begin
                valid[w] <= '0;
            end
            lru     <= '0;                   // every set starts with way 0 as victim
            valid_q <= '0;
            lru_q   <= 1'b0;
        end else begin
            if (tag_write) begin
                valid[write_way][lookup_set] <= 1'b1;
                lru[lookup_set]              <= ~write_way;  // fresh block is most recent
            end else if (lru_touch) begin
                lru[lookup_set] <= ~touch_way;
            end
            for (int w = 0; w < WAYS; w++) begin
                valid_q[w] <= valid[w][lookup_set];
            end
            lru_q <= lru[lookup_set];
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_q[w] && (tag_q[w] == req_tag_q);
        end
    end

    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];          // way 0 when only way 0 matches
    assign victim_way = lru_q;

    // a fill always goes to a way that missed, so one tag never sits in both ways
    assert property (@(posedge clk) disable iff (reset) !(&way_hit))
        else $error("tag_lookup: hit in both ways of one set");

endmodule

// File: tb.f
cache_pkg.sv
tag_lookup.sv
cache_controller.sv
data_store.sv
mem_port.sv
cache_top.sv
main_memory_model.sv
tb_cache.sv

// File: tb_cache.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the two-way L1 data cache: runs read and write misses,
// hits and an LRU replacement against the main memory model; concurrent
// assertions check every response and the error counts close the run
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_cache
    import cache_pkg::*;
();

    localparam int MEM_LATENCY     = 4;        // cycles from a read to its mem_valid
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_REQS        = 13;       // requests issued by the stimulus below
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * NUM_REQS;

    logic              clk = 1'b0;
    logic              reset;
    logic              enable;
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data_in;
    logic [DATA_W-1:0] data_out;
    logic              data_valid;
    logic              mem_enable;
    logic              mem_wr;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_in;
    logic [DATA_W-1:0] mem_out;
    logic              mem_valid;

    string             test_name;              // name of the open request
    logic              expect_hit;             // request should be served without a fill
    logic [DATA_W-1:0] exp_data;               // word a read must return
    logic [ADDR_W-1:0] fill_base;              // block base of the open request
    logic [DATA_W-1:0] shadow [int];           // written words, keyed by word address
    logic              req_seen;               // first enable has been sampled
    logic              dv_seen;                // data_valid already seen for this request
    logic [15:0]       reads_seen;             // memory reads since the last enable
    logic [15:0]       since_enable;           // cycles since enable was sampled
    int                mismatch_count = 0;
    int                failure_count  = 0;
    int                seed;
    int                rnd;

    always #5 clk = ~clk;                      // 10 ns period

    cache_top #(.SET_BITS(SET_BITS)) UUT (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .wr         (wr),
        .addr       (addr),
        .data_in    (data_in),
        .mem_out    (mem_out),
        .mem_valid  (mem_valid),
        .data_out   (data_out),
        .data_valid (data_valid),
        .mem_enable (mem_enable),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_in     (mem_in)
    );

    main_memory_model #(.LATENCY(MEM_LATENCY)) u_memory (
        .clk        (clk),
        .reset      (reset),
        .mem_enable (mem_enable),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_in     (mem_in),
        .mem_out    (mem_out),
        .mem_valid  (mem_valid)
    );

    task automatic report_mismatch(input string what, input logic [15:0] expected,
                                   input logic [15:0] actual);
        mismatch_count++;
        $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
    endtask

    task automatic report_failure(input string what);
        failure_count++;
        $display("failure in %s: %s", test_name, what);
    endtask

    // tag, set and word fields of a byte address, byte bit zero
    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_BITS-1:0] tag,
                                                    input logic [SET_BITS-1:0] set,
                                                    input logic [WORD_BITS-1:0] word);
        return {tag, set, word, 1'b0};
    endfunction

    // the preload pattern unless the word has been written since
    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] a);
        int key;
        key = int'(a[ADDR_W-1:1]);
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return {1'b0, a[ADDR_W-1:1]} ^ 16'hA5A5;
    endfunction

    // one request: enable for one cycle, then wait for data_valid and one idle cycle
    task automatic run_request(input string name, input logic is_write,
                               input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] wdata,
                               input logic hit_expected);
        test_name  <= name;
        enable     <= 1'b1;
        wr         <= is_write;
        addr       <= a;
        data_in    <= wdata;
        expect_hit <= hit_expected;
        exp_data   <= expected_word(a);
        fill_base  <= {a[ADDR_W-1:4], 4'b0000};
        if (is_write) begin
            shadow[int'(a[ADDR_W-1:1])] = wdata;   // memory holds it after the write-through
        end
        @(posedge clk);
        enable <= 1'b0;
        do @(posedge clk); while (!data_valid);   // watchdog catches a lost request
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            req_seen     <= 1'b0;
            dv_seen      <= 1'b0;
            reads_seen   <= '0;
            since_enable <= '0;
        end else if (enable) begin
            req_seen     <= 1'b1;
            dv_seen      <= 1'b0;
            reads_seen   <= '0;
            since_enable <= 16'd1;                 // data_valid is due when this reads 2
        end else begin
            since_enable <= since_enable + 16'd1;
            if (mem_enable && !mem_wr) begin
                reads_seen <= reads_seen + 16'd1;
            end
            if (data_valid) begin
                dv_seen <= 1'b1;
            end
        end
    end

    // nothing moves on either side between reset and the first request
    assert property (@(posedge clk) disable iff (reset)
        !req_seen |-> !data_valid && !mem_enable && !mem_wr)
        else report_failure("data_valid or a memory strobe was high before any request");

    assert property (@(posedge clk) disable iff (reset)
        data_valid && !wr |-> data_out == exp_data)
        else report_mismatch("read data", $sampled(exp_data), $sampled(data_out));

    // a hit reads nothing, a miss reads exactly one block
    assert property (@(posedge clk) disable iff (reset)
        data_valid |-> reads_seen == (expect_hit ? 16'd0 : 16'd8))
        else report_mismatch("memory reads", $sampled(expect_hit ? 16'd0 : 16'd8),
                             $sampled(reads_seen));

    // fill reads walk the block from offset 0 upwards, two bytes a step
    assert property (@(posedge clk) disable iff (reset)
        mem_enable && !mem_wr |-> mem_addr == fill_base + (reads_seen << 1))
        else report_mismatch("fill address", $sampled(fill_base + (reads_seen << 1)),
                             $sampled(mem_addr));

    assert property (@(posedge clk) disable iff (reset)
        data_valid && expect_hit |-> since_enable == 16'd2)
        else report_mismatch("hit latency", 16'd2, $sampled(since_enable));

    assert property (@(posedge clk) disable iff (reset)
        data_valid |-> !dv_seen)
        else report_failure("data_valid pulsed more than once for one request");

    // the write-through sits in the data_valid cycle of a write and nowhere else
    assert property (@(posedge clk) disable iff (reset)
        data_valid && wr |-> mem_enable && mem_wr)
        else report_failure("a completed write sent no write-through to memory");

    assert property (@(posedge clk) disable iff (reset)
        mem_wr |-> mem_enable && data_valid && wr)
        else report_failure("mem_wr was high outside the completion of a write");

    assert property (@(posedge clk) disable iff (reset)
        mem_enable && mem_wr |-> mem_addr == addr)
        else report_mismatch("write-through address", $sampled(addr), $sampled(mem_addr));

    assert property (@(posedge clk) disable iff (reset)
        mem_enable && mem_wr |-> mem_in == data_in)
        else report_mismatch("write-through data", $sampled(data_in), $sampled(mem_in));

    initial begin : stimulus
        logic [TAG_BITS-1:0] tag_a;
        logic [SET_BITS-1:0] set_0;
        logic [SET_BITS-1:0] lru_set;
        logic [ADDR_W-1:0]   wr_addr;
        reset      <= 1'b1;
        enable     <= 1'b0;
        wr         <= 1'b0;
        addr       <= '0;
        data_in    <= '0;
        test_name  <= "reset";
        expect_hit <= 1'b0;
        exp_data   <= '0;
        fill_base  <= '0;
        seed = 55754;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);                 // quiet interval for the reset check
        rnd   = $random(seed);
        tag_a = rnd[TAG_BITS-1:0];
        set_0 = rnd[8 +: SET_BITS];
        rnd   = $random(seed);
        run_request("read_miss", 1'b0, make_addr(tag_a, set_0, rnd[2:0]), '0, 1'b0);
        run_request("read_hit", 1'b0, make_addr(tag_a, set_0, rnd[5:3]), '0, 1'b1);
        run_request("read_hit", 1'b0, make_addr(tag_a, set_0, rnd[8:6]), '0, 1'b1);
        rnd     = $random(seed);
        wr_addr = make_addr(tag_a, set_0, rnd[2:0]);
        run_request("write_hit", 1'b1, wr_addr, rnd[31:16], 1'b1);
        run_request("write_hit_readback", 1'b0, wr_addr, '0, 1'b1);
        rnd     = $random(seed);
        wr_addr = make_addr(rnd[TAG_BITS-1:0], set_0 ^ 6'h20, rnd[10:8]);  // untouched set
        run_request("write_miss", 1'b1, wr_addr, rnd[31:16], 1'b0);
        run_request("write_miss_readback", 1'b0, wr_addr, '0, 1'b1);
        // tags A, B and C fight over one fresh set
        lru_set = set_0 ^ 6'h10;
        run_request("lru_a_miss", 1'b0, make_addr(tag_a, lru_set, 3'd1), '0, 1'b0);
        run_request("lru_b_miss", 1'b0, make_addr(tag_a ^ 6'h01, lru_set, 3'd2), '0, 1'b0);
        run_request("lru_a_hit", 1'b0, make_addr(tag_a, lru_set, 3'd3), '0, 1'b1);
        run_request("lru_c_replaces_b", 1'b0, make_addr(tag_a ^ 6'h02, lru_set, 3'd4), '0,
                    1'b0);
        run_request("lru_a_still_hit", 1'b0, make_addr(tag_a, lru_set, 3'd5), '0, 1'b1);
        run_request("lru_b_refill", 1'b0, make_addr(tag_a ^ 6'h01, lru_set, 3'd6), '0, 1'b0);
        repeat (4) @(posedge clk);
        $display("checks done: %0d value mismatches, %0d protocol failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run still going after %0d cycles, a request never completed",
                 WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule
